//--- logic/spu_pkg.sv
`default_nettype none

package spu_pkg;

    // ----------------------------------------
    // datapath widths
    // ----------------------------------------
    typedef logic signed [15:0] op0_t;      // signed multiplicand
    typedef logic        [15:0] op1_t;      // unsigned multiplier
    typedef logic signed [31:0] prod_t;     // exact s16 x u16 product
    typedef logic signed [39:0] acc_t;      // running sum, wraps
    typedef logic        [4:0]  shift_t;    // right shift 0..31

    localparam int mul_latency  = 3;        // enabled cycles through the multiplier
    localparam int max_inflight = 4;        // issued but not yet absorbed

    typedef logic [$clog2(max_inflight + 1) - 1:0] cnt_t;

    // ----------------------------------------
    // host bus
    // ----------------------------------------
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    localparam apb_addr_t reg_op0    = 8'h00;   // rw
    localparam apb_addr_t reg_op1    = 8'h04;   // rw
    localparam apb_addr_t reg_cmd    = 8'h08;   // wo, bit 0 clear, write issues
    localparam apb_addr_t reg_shift  = 8'h0C;   // rw
    localparam apb_addr_t reg_acc_lo = 8'h10;   // ro, sum 31..0
    localparam apb_addr_t reg_acc_hi = 8'h14;   // ro, sum 39..32 sign extended
    localparam apb_addr_t reg_status = 8'h18;   // ro, busy and count

    typedef enum logic [1:0] {
        apb_idle,
        apb_setup,
        apb_access_wait
    } apb_state_e;

endpackage

`default_nettype wire

//--- logic/spu_op_mulsu.sv
`timescale 1ns/100ps
`default_nettype none

module spu_op_mulsu (
    input  logic           clk,
    input  logic           reset,
    input  logic           cke,
    input  spu_pkg::op0_t  s_data0,
    input  spu_pkg::op1_t  s_data1,
    input  logic           s_valid,
    input  logic           s_clear,
    output spu_pkg::prod_t m_data,
    output logic           m_valid,
    output logic           m_clear
);

    // both operands widened by one bit so a signed multiply covers s16 x u16
    logic signed [$bits(spu_pkg::op0_t):0]       a_r;
    logic signed [$bits(spu_pkg::op1_t):0]       b_r;
    logic signed [2*$bits(spu_pkg::op0_t)+1:0]   mul_full;
    spu_pkg::prod_t                              mul_r;

    logic [spu_pkg::mul_latency-1:0] vld_sr;    // side-band chain, one bit per stage
    logic [spu_pkg::mul_latency-1:0] clr_sr;

    // ----------------------------------------
    // stage 0: input register
    // ----------------------------------------
    // a new item is taken even while the pipe is held, so an issue
    // from the host side is not lost during a cke drop
    always_ff @(posedge clk) begin
        if (s_valid) begin
            a_r <= {s_data0[$bits(spu_pkg::op0_t)-1], s_data0};   // sign extend
            b_r <= {1'b0, s_data1};                                // zero extend
        end
    end

    assign mul_full = a_r * b_r;

    // ----------------------------------------
    // stage 1 and 2: multiply and output
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (cke) begin
            mul_r  <= spu_pkg::prod_t'(mul_full);   // upper bits are pure sign
            m_data <= mul_r;
        end
    end

    // ----------------------------------------
    // valid / clear side-band
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            vld_sr <= '0;
            clr_sr <= '0;
        end else begin
            if (cke) begin
                vld_sr[spu_pkg::mul_latency-1:1] <= vld_sr[spu_pkg::mul_latency-2:0];
                clr_sr[spu_pkg::mul_latency-1:1] <= clr_sr[spu_pkg::mul_latency-2:0];
            end
            if (s_valid) begin
                vld_sr[0] <= 1'b1;
                clr_sr[0] <= s_clear;
            end else if (cke) begin
                vld_sr[0] <= 1'b0;              // item moved on to stage 1
                clr_sr[0] <= 1'b0;
            end
        end
    end

    assign m_valid = vld_sr[spu_pkg::mul_latency-1];
    assign m_clear = clr_sr[spu_pkg::mul_latency-1];

endmodule

`default_nettype wire

//--- logic/spu_op_accum.sv
`timescale 1ns/100ps
`default_nettype none

module spu_op_accum (
    input  logic             clk,
    input  logic             reset,
    input  logic             cke,
    input  spu_pkg::prod_t   s_data,
    input  logic             s_valid,
    input  logic             s_clear,
    input  spu_pkg::shift_t  shift,
    output spu_pkg::acc_t    m_acc,
    output logic             m_done
);

    spu_pkg::acc_t prod_ext;    // product widened to the sum
    spu_pkg::acc_t term;        // contribution after the shift
    logic          take;

    // ----------------------------------------
    // scale the incoming product
    // ----------------------------------------
    assign prod_ext = {{8{s_data[31]}}, s_data};
    assign term     = prod_ext >>> shift;           // arithmetic, floors negatives

    // a held datapath ignores the incoming valid
    assign take = cke & s_valid;

    // ----------------------------------------
    // running sum
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            m_acc  <= '0;
            m_done <= 1'b0;
        end else begin
            m_done <= take;                         // one pulse per absorbed item
            if (take) begin
                if (s_clear) begin
                    m_acc <= term;                  // restart from this product
                end else begin
                    m_acc <= m_acc + term;          // wraps modulo 2^40
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/spu_apb_regs.sv
`timescale 1ns/100ps
`default_nettype none

module spu_apb_regs (
    input  logic                clk,
    input  logic                reset,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  spu_pkg::apb_addr_t  paddr,
    input  spu_pkg::apb_data_t  pwdata,
    output spu_pkg::apb_data_t  prdata,
    output logic                pready,
    output logic                pslverr,
    input  spu_pkg::acc_t       acc,
    input  logic                acc_done,
    output spu_pkg::op0_t       op0,
    output spu_pkg::op1_t       op1,
    output spu_pkg::shift_t     shift,
    output logic                issue_valid,
    output logic                issue_clear
);

    spu_pkg::apb_state_e state;
    spu_pkg::cnt_t       count;         // items issued and not yet absorbed

    logic busy;
    logic full;
    logic addr_ok;
    logic read_only;
    logic err;
    logic stall;
    logic access;
    logic done;

    assign busy = (count != '0);
    assign full = (count == spu_pkg::cnt_t'(spu_pkg::max_inflight));

    // ----------------------------------------
    // address decode
    // ----------------------------------------
    always_comb begin
        addr_ok   = 1'b1;
        read_only = 1'b0;
        case (paddr)
            spu_pkg::reg_op0,
            spu_pkg::reg_op1,
            spu_pkg::reg_cmd,
            spu_pkg::reg_shift:  read_only = 1'b0;
            spu_pkg::reg_acc_lo,
            spu_pkg::reg_acc_hi,
            spu_pkg::reg_status: read_only = 1'b1;
            default:             addr_ok   = 1'b0;
        endcase
    end

    assign err = !addr_ok || (pwrite && read_only);

    // wait states: a full pipe blocks issue, a busy pipe blocks sum reads
    assign stall = !err && (
                   (pwrite && (paddr == spu_pkg::reg_cmd) && full) ||
                   (!pwrite && busy && ((paddr == spu_pkg::reg_acc_lo) ||
                                        (paddr == spu_pkg::reg_acc_hi))));

    assign access = psel && penable && (state != spu_pkg::apb_idle);
    assign done   = access && !stall;   // transfer completes this cycle

    assign pready  = !(access && stall);
    assign pslverr = done && err;

    // ----------------------------------------
    // access state machine
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= spu_pkg::apb_idle;
        end else begin
            case (state)
                spu_pkg::apb_idle: begin
                    if (psel && !penable) begin
                        state <= spu_pkg::apb_setup;
                    end
                end
                default: begin
                    if (!psel) begin
                        state <= spu_pkg::apb_idle;                 // master gave up
                    end else if (penable) begin
                        state <= stall ? spu_pkg::apb_access_wait : spu_pkg::apb_idle;
                    end
                end
            endcase
        end
    end

    // ----------------------------------------
    // write side
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            op0   <= '0;
            op1   <= '0;
            shift <= '0;
        end else if (done && pwrite && !err) begin
            case (paddr)
                spu_pkg::reg_op0:   op0   <= pwdata[15:0];
                spu_pkg::reg_op1:   op1   <= pwdata[15:0];
                spu_pkg::reg_shift: shift <= pwdata[4:0];
                default:            ;                               // cmd handled below
            endcase
        end
    end

    assign issue_valid = done && pwrite && !err && (paddr == spu_pkg::reg_cmd);
    assign issue_clear = pwdata[0];

    // in-flight counter, issue and absorb may coincide
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (issue_valid && !acc_done) begin
            count <= count + spu_pkg::cnt_t'(1);
        end else if (!issue_valid && acc_done) begin
            count <= count - spu_pkg::cnt_t'(1);
        end
    end

    // ----------------------------------------
    // read side
    // ----------------------------------------
    always_comb begin
        case (paddr)
            spu_pkg::reg_op0:    prdata = {{16{op0[15]}}, op0};
            spu_pkg::reg_op1:    prdata = {16'h0000, op1};
            spu_pkg::reg_shift:  prdata = {27'd0, shift};
            spu_pkg::reg_acc_lo: prdata = acc[31:0];
            spu_pkg::reg_acc_hi: prdata = {{24{acc[39]}}, acc[39:32]};
            spu_pkg::reg_status: prdata = {27'd0, count, 1'b0, busy};
            default:             prdata = '0;                   // cmd reads as zero
        endcase
    end

endmodule

`default_nettype wire

//--- logic/spu_mac_top.sv
`timescale 1ns/100ps
`default_nettype none

module spu_mac_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                cke,        // datapath hold when low
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  spu_pkg::apb_addr_t  paddr,
    input  spu_pkg::apb_data_t  pwdata,
    output spu_pkg::apb_data_t  prdata,
    output logic                pready,
    output logic                pslverr
);

    // ----------------------------------------
    // internal nets
    // ----------------------------------------
    logic             issue_valid;
    logic             issue_clear;
    spu_pkg::op0_t    op0;
    spu_pkg::op1_t    op1;
    spu_pkg::shift_t  shift;
    spu_pkg::prod_t   prod;
    logic             prod_valid;
    logic             prod_clear;
    spu_pkg::acc_t    acc;
    logic             acc_done;

    spu_apb_regs u_regs (
        .clk         (clk),
        .reset       (reset),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .acc         (acc),
        .acc_done    (acc_done),
        .op0         (op0),
        .op1         (op1),
        .shift       (shift),
        .issue_valid (issue_valid),
        .issue_clear (issue_clear)
    );

    // three enabled cycles of multiply
    spu_op_mulsu u_mul (
        .clk     (clk),
        .reset   (reset),
        .cke     (cke),
        .s_data0 (op0),
        .s_data1 (op1),
        .s_valid (issue_valid),
        .s_clear (issue_clear),
        .m_data  (prod),
        .m_valid (prod_valid),
        .m_clear (prod_clear)
    );

    // one more enabled cycle into the sum
    spu_op_accum u_acc (
        .clk     (clk),
        .reset   (reset),
        .cke     (cke),
        .s_data  (prod),
        .s_valid (prod_valid),
        .s_clear (prod_clear),
        .shift   (shift),
        .m_acc   (acc),
        .m_done  (acc_done)
    );

endmodule

`default_nettype wire

//--- sim/tb_spu_mac_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_spu_mac_top;

    logic                clk;
    logic                reset;
    logic                cke;
    logic                psel;
    logic                penable;
    logic                pwrite;
    spu_pkg::apb_addr_t  paddr;
    spu_pkg::apb_data_t  pwdata;
    spu_pkg::apb_data_t  prdata;
    logic                pready;
    logic                pslverr;

    integer seed;
    integer errors;
    integer tests;
    integer test_fails;

    localparam integer apb_timeout = 200;   // cycles of pready low per access

    spu_mac_top dut0 (
        .clk     (clk),
        .reset   (reset),
        .cke     (cke),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // random cke drops but never two low cycles in a row
    initial begin : cke_gen
        integer r;
        seed = 72;
        cke = 1'b1;
        forever begin
            @(posedge clk);
            r = $random(seed);
            if (reset) begin
                cke <= 1'b1;
            end else if (cke && (r % 10 == 0)) begin
                cke <= 1'b0;
            end else begin
                cke <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    task automatic check(input string name, input logic [39:0] expected,
                         input logic [39:0] actual);
        if (expected !== actual) begin
            $display("ERR %0s expected %h actual %h", name, expected, actual);
            errors = errors + 1;
            test_fails = test_fails + 1;
        end
    endtask

    // one APB transfer that returns read data, slave error and wait states
    task automatic apb_xfer(input logic write, input spu_pkg::apb_addr_t addr,
                            input spu_pkg::apb_data_t wdata,
                            output spu_pkg::apb_data_t rdata,
                            output logic err, output integer waits);
        integer n;
        logic got;
        n = 0;
        got = 1'b0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        while (!got && n < apb_timeout) begin
            @(posedge clk);
            if (pready) begin
                got = 1'b1;
            end else begin
                n = n + 1;
            end
        end
        if (!got) begin
            $display("timeout: pready stayed low on access to offset %h", addr);
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            rdata   = prdata;
            err     = pslverr;
            waits   = n;
            psel    <= 1'b0;
            penable <= 1'b0;
        end
    endtask

    task automatic apb_write(input spu_pkg::apb_addr_t addr, input spu_pkg::apb_data_t wdata,
                             output logic err);
        spu_pkg::apb_data_t unused;
        integer w;
        apb_xfer(1'b1, addr, wdata, unused, err, w);
    endtask

    task automatic apb_read(input spu_pkg::apb_addr_t addr, output spu_pkg::apb_data_t rdata,
                            output logic err, output integer waits);
        apb_xfer(1'b0, addr, 32'd0, rdata, err, waits);
    endtask

    // full 40-bit sum from the two halves, high word sign extended
    task automatic read_sum(input string name, input logic [39:0] expected,
                            output integer waits);
        spu_pkg::apb_data_t lo;
        spu_pkg::apb_data_t hi;
        logic e;
        integer w;
        apb_read(spu_pkg::reg_acc_lo, lo, e, waits);
        check("acc_lo_err", 40'd0, {39'd0, e});
        apb_read(spu_pkg::reg_acc_hi, hi, e, w);
        check("acc_hi_err", 40'd0, {39'd0, e});
        check(name, expected, {hi[7:0], lo});
        check({name, "_hi_ext"}, {16'd0, {24{expected[39]}}}, {16'd0, hi[31:8]});
    endtask

    // s16 times u16 wrapped to the sum width
    function automatic logic [39:0] product(input logic [15:0] a, input logic [15:0] b);
        longint sa;
        longint ub;
        longint p;
        sa = a[15] ? longint'({48'hffffffffffff, a}) : longint'({48'd0, a});
        ub = longint'({48'd0, b});
        p  = sa * ub;
        return p[39:0];
    endfunction

    task automatic finish_test(input string name, input integer idx);
        tests = tests + 1;
        $display("test %0s %0d: %0s", name, idx, (test_fails == 0) ? "ok" : "mismatch");
        test_fails = 0;
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin : main
        integer fd;
        integer code;
        integer idx;
        integer clr;
        integer sh;
        integer waits;
        string line;
        reg [8*12-1:0] tag;
        logic [15:0] a;
        logic [15:0] b;
        logic [39:0] exp_sum;
        logic [39:0] expected;
        spu_pkg::apb_data_t rd;
        logic e;

        errors = 0;
        tests = 0;
        test_fails = 0;
        idx = 0;
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        // corner, accumulation and shift items from the pattern file
        fd = $fopen("sim/mac_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/mac_patterns.txt");
            errors = errors + 1;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.getc(0) != 8'h23) begin
                    code = $sscanf(line, "%s %h %h %d %d %h", tag, a, b, clr, sh, exp_sum);
                    if (code == 6) begin
                        idx = idx + 1;
                        apb_write(spu_pkg::reg_op0, {16'd0, a}, e);
                        check("op0_err", 40'd0, {39'd0, e});
                        apb_write(spu_pkg::reg_op1, {16'd0, b}, e);
                        check("op1_err", 40'd0, {39'd0, e});
                        apb_write(spu_pkg::reg_shift, {27'd0, sh[4:0]}, e);
                        check("shift_err", 40'd0, {39'd0, e});
                        apb_read(spu_pkg::reg_op0, rd, e, waits);
                        check("op0_read", {24'd0, a}, {24'd0, rd[15:0]});
                        apb_read(spu_pkg::reg_op1, rd, e, waits);
                        check("op1_read", {24'd0, b}, {24'd0, rd[15:0]});
                        apb_read(spu_pkg::reg_shift, rd, e, waits);
                        check("shift_read", {35'd0, sh[4:0]}, {35'd0, rd[4:0]});
                        apb_write(spu_pkg::reg_cmd, {31'd0, clr[0]}, e);
                        check("cmd_err", 40'd0, {39'd0, e});
                        read_sum($sformatf("%0s_%0d", tag, idx), exp_sum, waits);
                        finish_test($sformatf("%0s", tag), idx);
                    end
                end
            end
            $fclose(fd);
        end

        // five issues in a row and a sum read that waits for the drain
        a = 16'h8123;
        b = 16'hb456;
        apb_write(spu_pkg::reg_op0, {16'd0, a}, e);
        apb_write(spu_pkg::reg_op1, {16'd0, b}, e);
        apb_write(spu_pkg::reg_shift, 32'd0, e);
        apb_write(spu_pkg::reg_cmd, 32'd1, e);
        repeat (4) apb_write(spu_pkg::reg_cmd, 32'd0, e);
        expected = product(a, b) * 40'd5;
        read_sum("pipe_sum", expected, waits);
        check("pipe_read_waited", 40'd1, {39'd0, (waits > 0)});
        apb_read(spu_pkg::reg_status, rd, e, waits);
        check("pipe_status", 40'd0, {35'd0, rd[4:2], 1'b0, rd[0]});
        finish_test("pipeline", 0);

        // slave errors leave the sum alone
        apb_read(8'h1C, rd, e, waits);
        check("undef_offset_err", 40'd1, {39'd0, e});
        apb_write(spu_pkg::reg_acc_lo, 32'h5a5a5a5a, e);
        check("ro_write_err", 40'd1, {39'd0, e});
        read_sum("err_sum_kept", expected, waits);
        finish_test("errors", 0);

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/mac_patterns.txt
# columns: test op0(hex, signed) op1(hex, unsigned) clear shift expected_sum(hex, 40 bit)
# expected is the sum after the item, products shifted right arithmetically
corner 0000 ffff 1 0 0000000000
corner 7fff ffff 1 0 007ffe8001
corner 8000 ffff 1 0 ff80008000
corner ffff ffff 1 0 ffffff0001
corner 8000 0001 1 0 ffffff8000
corner 7fff 0001 1 0 0000007fff
corner 0001 8000 1 0 0000008000
corner 0400 0010 1 0 0000004000
corner 8000 8000 1 0 ffc0000000
corner ffff 0001 1 0 ffffffffff
accum 0010 0010 1 0 0000000100
accum 7fff ffff 0 0 007ffe8101
accum 7fff ffff 0 0 00fffd0102
accum 7fff ffff 0 0 017ffb8103
accum 8000 ffff 0 0 00fffc0103
accum ffff 0003 0 0 00fffc0100
accum 0005 0007 0 0 00fffc0123
accum 0001 0001 1 0 0000000001
accum 8000 ffff 0 0 ff80008001
accum 8000 ffff 0 0 ff00010001
shift 7fff ffff 1 4 0007ffe800
shift ffff 0001 0 1 0007ffe7ff
shift ffff 0003 0 1 0007ffe7fd
shift 0005 0001 0 1 0007ffe7ff
shift 8000 ffff 0 31 0007ffe7fe
shift 7fff ffff 0 31 0007ffe7fe
shift 8000 8000 1 30 ffffffffff
shift 0003 0001 0 0 0000000002

//--- filelist.f
logic/spu_pkg.sv
logic/spu_op_mulsu.sv
logic/spu_op_accum.sv
logic/spu_apb_regs.sv
logic/spu_mac_top.sv
sim/tb_spu_mac_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the MAC testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f filelist.f --top-module tb_spu_mac_top -o tb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
    exit 1
fi
exit 0
